//--- rat.sv
`timescale 1ns/1ps

module rat (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              run,
    input  logic                                              clear,
    input  rename_pkg::rename_slot_t   [rename_pkg::GROUP_W-1:0] rename_in,
    input  rename_pkg::rob_tag_t       [rename_pkg::GROUP_W-1:0] alloc_tag,
    input  rename_pkg::retire_slot_t   [rename_pkg::GROUP_W-1:0] retire_in,
    input  rename_pkg::rob_tag_t       [rename_pkg::GROUP_W-1:0] retire_tag,
    output rename_pkg::rename_result_t [rename_pkg::GROUP_W-1:0] rename_out
);
    import rename_pkg::*;

    map_entry_t [NUM_AREGS-1:0] map_q;
    map_entry_t [NUM_AREGS-1:0] map_d;

    // slot carries a real destination this cycle
    logic [GROUP_W-1:0] has_dest;
    // slot actually updates the table
    logic [GROUP_W-1:0] wen;

    always_comb begin
        for (int i = 0; i < GROUP_W; i++) begin
            has_dest[i] = run && rename_in[i].valid && (rename_in[i].dest != '0);
        end
    end

    // younger slot to the same register masks the older write
    always_comb begin
        for (int i = 0; i < GROUP_W; i++) begin
            wen[i] = has_dest[i];
            for (int j = i + 1; j < GROUP_W; j++) begin
                if (has_dest[j] && (rename_in[j].dest == rename_in[i].dest)) begin
                    wen[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        map_d = map_q;
        // release only if the entry still points at the retiring tag
        if (run) begin
            for (int j = 0; j < GROUP_W; j++) begin
                if (retire_in[j].valid && (retire_in[j].dest != '0)
                        && map_q[retire_in[j].dest].valid
                        && (map_q[retire_in[j].dest].tag == retire_tag[j])) begin
                    map_d[retire_in[j].dest] = '0;
                end
            end
        end
        // new mappings applied last, so they beat a release
        for (int i = 0; i < GROUP_W; i++) begin
            if (wen[i]) begin
                map_d[rename_in[i].dest].valid = 1'b1;
                map_d[rename_in[i].dest].tag = alloc_tag[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            map_q <= '0;
        end else begin
            map_q <= map_d;
        end
    end

    // lookups with bypass from older slots in the group
    always_comb begin
        for (int i = 0; i < GROUP_W; i++) begin
            rename_out[i].dest_tag = alloc_tag[i];
            rename_out[i].dest_valid = has_dest[i];
            rename_out[i].src0 = map_q[rename_in[i].src0];
            rename_out[i].src1 = map_q[rename_in[i].src1];
            // ascending order lets the youngest older producer win
            for (int j = 0; j < i; j++) begin
                if (has_dest[j] && (rename_in[j].dest == rename_in[i].src0)) begin
                    rename_out[i].src0.valid = 1'b1;
                    rename_out[i].src0.tag = alloc_tag[j];
                end
                if (has_dest[j] && (rename_in[j].dest == rename_in[i].src1)) begin
                    rename_out[i].src1.valid = 1'b1;
                    rename_out[i].src1.tag = alloc_tag[j];
                end
            end
        end
    end

endmodule

//--- rename_ctrl.sv
`timescale 1ns/1ps

module rename_ctrl (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            flush,
    input  rename_pkg::retire_slot_t [rename_pkg::GROUP_W-1:0] retire_in,
    output logic                                            run,
    output logic                                            clear,
    output logic [rename_pkg::CREDIT_W-1:0]                 credit_return
);
    import rename_pkg::*;

    ctrl_state_t state;
    logic [GRANT_CNT_W-1:0] grant_cnt;
    logic grant_last;

    assign grant_last = (grant_cnt == GRANT_CNT_W'(GRANT_CYCLES - 1));

    // inputs dropped during the flush pulse and until the grant ends
    assign run = (state == ST_RUN) && !flush;
    assign clear = (state == ST_FLUSH);

    // grant_cnt counts grants already issued; the flush cycle issues the first one
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_GRANT;
            grant_cnt <= '0;
            credit_return <= '0;
        end else if (flush) begin
            state <= ST_FLUSH;
            grant_cnt <= '0;
            credit_return <= '0;
        end else begin
            case (state)
                ST_GRANT: begin
                    credit_return <= CREDIT_W'(GROUP_W);
                    grant_cnt <= grant_cnt + 1'b1;
                    if (grant_last) begin
                        state <= ST_RUN;
                    end
                end
                ST_FLUSH: begin
                    credit_return <= CREDIT_W'(GROUP_W);
                    grant_cnt <= GRANT_CNT_W'(1);
                    state <= ST_GRANT;
                end
                ST_RUN: begin
                    // one credit back per retired instruction
                    credit_return <= count_retires(retire_in);
                end
                default: begin
                    state <= ST_GRANT;
                    grant_cnt <= '0;
                    credit_return <= '0;
                end
            endcase
        end
    end

endmodule

//--- rename_pkg.sv
package rename_pkg;

    localparam int NUM_AREGS = 32;
    localparam int AREG_W = 5;
    localparam int ROB_DEPTH = 16;
    localparam int TAG_W = 4;
    localparam int GROUP_W = 2;
    localparam int CREDIT_W = 2;

    // credits are handed out GROUP_W per cycle after reset or flush
    localparam int GRANT_CYCLES = ROB_DEPTH / GROUP_W;
    localparam int GRANT_CNT_W = $clog2(GRANT_CYCLES);

    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [TAG_W-1:0] rob_tag_t;

    // valid low means the value sits in the register file
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } map_entry_t;

    typedef struct packed {
        logic  valid;
        areg_t dest;
        areg_t src0;
        areg_t src1;
    } rename_slot_t;

    typedef struct packed {
        rob_tag_t   dest_tag;
        logic       dest_valid;
        map_entry_t src0;
        map_entry_t src1;
    } rename_result_t;

    typedef struct packed {
        logic  valid;
        areg_t dest;
    } retire_slot_t;

    typedef enum logic [1:0] {
        ST_GRANT,
        ST_RUN,
        ST_FLUSH
    } ctrl_state_t;

    function automatic logic [CREDIT_W-1:0] count_renames(rename_slot_t [GROUP_W-1:0] slots);
        logic [CREDIT_W-1:0] n;
        n = '0;
        for (int i = 0; i < GROUP_W; i++) begin
            n = n + CREDIT_W'(slots[i].valid);
        end
        return n;
    endfunction

    function automatic logic [CREDIT_W-1:0] count_retires(retire_slot_t [GROUP_W-1:0] slots);
        logic [CREDIT_W-1:0] n;
        n = '0;
        for (int i = 0; i < GROUP_W; i++) begin
            n = n + CREDIT_W'(slots[i].valid);
        end
        return n;
    endfunction

endpackage

//--- rename_properties.sv
`timescale 1ns/1ps

module rename_properties (
    input logic                                              clk,
    input logic                                              reset,
    input logic                                              run,
    input logic                                              clear,
    input rename_pkg::retire_slot_t [rename_pkg::GROUP_W-1:0] retire_in,
    input logic [rename_pkg::CREDIT_W-1:0]                   credit_return
);
    import rename_pkg::*;

    int granted;
    int retired;

    // totals since the last reset or flush
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            granted <= 0;
            retired <= 0;
        end else begin
            granted <= granted + int'(credit_return);
            if (run) begin
                retired <= retired + int'(retire_in[0].valid) + int'(retire_in[1].valid);
            end
        end
    end

    credit_max: assert property (@(posedge clk) disable iff (reset)
        credit_return <= CREDIT_W'(GROUP_W))
        else $error("credit_return exceeds the group width");

    credit_budget: assert property (@(posedge clk) disable iff (reset)
        granted <= ROB_DEPTH + retired)
        else $error("more credits granted than ROB entries plus retires");

    clear_pulse: assert property (@(posedge clk) disable iff (reset)
        $rose(clear) |=> !clear)
        else $error("clear held longer than one cycle");

endmodule

bind rename_top rename_properties u_props (
    .clk           (clk),
    .reset         (reset),
    .run           (run),
    .clear         (clear),
    .retire_in     (retire_in),
    .credit_return (credit_return)
);

//--- rename_top.sv
`timescale 1ns/1ps

module rename_top (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              flush,
    input  rename_pkg::rename_slot_t   [rename_pkg::GROUP_W-1:0] rename_in,
    input  rename_pkg::retire_slot_t   [rename_pkg::GROUP_W-1:0] retire_in,
    output rename_pkg::rename_result_t [rename_pkg::GROUP_W-1:0] rename_out,
    output logic [rename_pkg::CREDIT_W-1:0]                   credit_return
);
    import rename_pkg::*;

    logic run;
    logic clear;
    rob_tag_t [GROUP_W-1:0] alloc_tag;
    rob_tag_t [GROUP_W-1:0] retire_tag;

    rename_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .retire_in     (retire_in),
        .run           (run),
        .clear         (clear),
        .credit_return (credit_return)
    );

    rob_pointers u_ptrs (
        .clk        (clk),
        .reset      (reset),
        .clear      (clear),
        .rename_in  (rename_in),
        .retire_in  (retire_in),
        .run        (run),
        .alloc_tag  (alloc_tag),
        .retire_tag (retire_tag)
    );

    rat u_rat (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .clear      (clear),
        .rename_in  (rename_in),
        .alloc_tag  (alloc_tag),
        .retire_in  (retire_in),
        .retire_tag (retire_tag),
        .rename_out (rename_out)
    );

endmodule

//--- rob_pointers.sv
`timescale 1ns/1ps

module rob_pointers (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            clear,
    input  rename_pkg::rename_slot_t [rename_pkg::GROUP_W-1:0] rename_in,
    input  rename_pkg::retire_slot_t [rename_pkg::GROUP_W-1:0] retire_in,
    input  logic                                            run,
    output rename_pkg::rob_tag_t     [rename_pkg::GROUP_W-1:0] alloc_tag,
    output rename_pkg::rob_tag_t     [rename_pkg::GROUP_W-1:0] retire_tag
);
    import rename_pkg::*;

    // ring pointers wrap at ROB_DEPTH through the tag width
    rob_tag_t tail;
    rob_tag_t head;

    logic [CREDIT_W-1:0] alloc_cnt;
    logic [CREDIT_W-1:0] retire_cnt;

    assign alloc_cnt = count_renames(rename_in);
    assign retire_cnt = count_retires(retire_in);

    // slots are packed low, so slot i takes tail + i
    always_comb begin
        for (int i = 0; i < GROUP_W; i++) begin
            alloc_tag[i] = tail + TAG_W'(i);
            retire_tag[i] = head + TAG_W'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            tail <= '0;
            head <= '0;
        end else if (run) begin
            tail <= tail + TAG_W'(alloc_cnt);
            head <= head + TAG_W'(retire_cnt);
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module tb_rename -o sim_rename
./obj_dir/sim_rename | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi

//--- sources.f
rename_pkg.sv
rat.sv
rob_pointers.sv
rename_ctrl.sv
rename_top.sv
rename_properties.sv
tb_rename.sv

//--- tb_rename.sv
`timescale 1ns/1ps

module tb_rename;
    import rename_pkg::*;

    localparam int RANDOM_LEN = 300;
    localparam int TEST_LEN = 2 * GRANT_CYCLES + 3 * ROB_DEPTH + 2 * RANDOM_LEN + 40;
    localparam int MAX_CYCLES = 2 * TEST_LEN;

    logic clk;
    logic reset;
    logic flush;
    rename_slot_t [GROUP_W-1:0] rename_in;
    retire_slot_t [GROUP_W-1:0] retire_in;
    rename_result_t [GROUP_W-1:0] rename_out;
    logic [CREDIT_W-1:0] credit_return;

    // reference model state
    logic m_valid [NUM_AREGS];
    rob_tag_t m_tag [NUM_AREGS];
    rob_tag_t m_tail;
    areg_t q_areg [$];
    rob_tag_t q_tag [$];
    int credits;
    int exp_credit;
    rob_tag_t saved_tag;

    int seed = 31866;
    int errors = 0;
    int checks = 0;
    int test_errors = 0;
    int cycles = 0;

    rename_top dut (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .rename_in     (rename_in),
        .retire_in     (retire_in),
        .rename_out    (rename_out),
        .credit_return (credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check(input int actual, input int expected, input string msg);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("Mismatch at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
        end
    endtask

    task automatic check_src(input map_entry_t actual, input map_entry_t expected,
                             input string msg);
        check(int'(actual.valid), int'(expected.valid), {msg, " valid"});
        // tag is don't-care while the value sits in the register file
        if (expected.valid) begin
            check(int'(actual.tag), int'(expected.tag), {msg, " tag"});
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic model_clear();
        for (int r = 0; r < NUM_AREGS; r++) begin
            m_valid[r] = 1'b0;
            m_tag[r] = '0;
        end
        m_tail = '0;
        q_areg.delete();
        q_tag.delete();
        credits = 0;
        exp_credit = 0;
    endtask

    // credits seen this cycle can be spent at once
    task automatic begin_cycle(input bit check_credit);
        @(negedge clk);
        if (check_credit) begin
            check(int'(credit_return), exp_credit, "credit_return");
        end
        credits += int'(credit_return);
    endtask

    task automatic apply_cycle(input rename_slot_t [GROUP_W-1:0] ren,
                               input retire_slot_t [GROUP_W-1:0] ret);
        map_entry_t s0;
        map_entry_t s1;
        rob_tag_t exp_tag;
        int nr;
        rename_in = ren;
        retire_in = ret;
        #5;
        for (int i = 0; i < GROUP_W; i++) begin
            if (ren[i].valid) begin
                s0 = {m_valid[ren[i].src0], m_tag[ren[i].src0]};
                s1 = {m_valid[ren[i].src1], m_tag[ren[i].src1]};
                // older slots in the group forward their new tags
                for (int j = 0; j < i; j++) begin
                    if (ren[j].dest != '0 && ren[j].dest == ren[i].src0) begin
                        s0 = {1'b1, m_tail + TAG_W'(j)};
                    end
                    if (ren[j].dest != '0 && ren[j].dest == ren[i].src1) begin
                        s1 = {1'b1, m_tail + TAG_W'(j)};
                    end
                end
                exp_tag = m_tail + TAG_W'(i);
                check(int'(rename_out[i].dest_tag), int'(exp_tag),
                      $sformatf("slot %0d dest tag", i));
                check(int'(rename_out[i].dest_valid), int'(ren[i].dest != '0),
                      $sformatf("slot %0d dest valid", i));
                check_src(rename_out[i].src0, s0, $sformatf("slot %0d src0", i));
                check_src(rename_out[i].src1, s1, $sformatf("slot %0d src1", i));
            end
        end
        nr = 0;
        for (int j = 0; j < GROUP_W; j++) begin
            if (ret[j].valid) begin
                if (ret[j].dest != '0 && m_valid[ret[j].dest]
                        && m_tag[ret[j].dest] == q_tag[0]) begin
                    m_valid[ret[j].dest] = 1'b0;
                end
                q_tag.pop_front();
                q_areg.pop_front();
                nr++;
            end
        end
        // slot order makes the younger write win
        for (int i = 0; i < GROUP_W; i++) begin
            if (ren[i].valid) begin
                if (ren[i].dest != '0) begin
                    m_valid[ren[i].dest] = 1'b1;
                    m_tag[ren[i].dest] = m_tail;
                end
                q_areg.push_back(ren[i].dest);
                q_tag.push_back(m_tail);
                m_tail = m_tail + TAG_W'(1);
                credits--;
            end
        end
        exp_credit = nr;
    endtask

    task automatic drive_group(input int nv, input areg_t d0, input areg_t d1,
                               input areg_t s0, input areg_t s1, input int nr);
        rename_slot_t [GROUP_W-1:0] ren;
        retire_slot_t [GROUP_W-1:0] ret;
        begin_cycle(1'b1);
        ren = '0;
        ret = '0;
        for (int i = 0; i < nv; i++) begin
            ren[i] = {1'b1, (i == 0) ? d0 : d1, s0, s1};
        end
        for (int j = 0; j < nr; j++) begin
            ret[j] = {1'b1, q_areg[j]};
        end
        apply_cycle(ren, ret);
    endtask

    task automatic random_cycle();
        rename_slot_t [GROUP_W-1:0] ren;
        retire_slot_t [GROUP_W-1:0] ret;
        logic [31:0] r;
        int nv;
        int nr;
        begin_cycle(1'b1);
        r = $random(seed);
        nv = (int'(r[1:0]) % 3 > credits) ? credits : int'(r[1:0]) % 3;
        nr = (int'(r[3:2]) % 3 > q_tag.size()) ? q_tag.size() : int'(r[3:2]) % 3;
        ren = '0;
        ret = '0;
        for (int i = 0; i < nv; i++) begin
            r = $random(seed);
            // a narrow register range gives frequent collisions
            ren[i] = {1'b1, areg_t'(r[2:0]), areg_t'(r[10:8]), areg_t'(r[18:16])};
        end
        for (int j = 0; j < nr; j++) begin
            ret[j] = {1'b1, q_areg[j]};
        end
        apply_cycle(ren, ret);
    endtask

    task automatic drain();
        while (q_tag.size() > 0) begin
            drive_group(0, '0, '0, '0, '0, (q_tag.size() < GROUP_W) ? q_tag.size() : GROUP_W);
        end
    endtask

    initial begin
        reset = 1'b1;
        flush = 1'b0;
        rename_in = '0;
        retire_in = '0;
        model_clear();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int k = 0; k < GRANT_CYCLES; k++) begin
            begin_cycle(1'b0);
            check(int'(credit_return), GROUP_W, "grant after reset");
            apply_cycle('0, '0);
        end
        repeat (2) drive_group(0, '0, '0, '0, '0, 0);
        check(credits, ROB_DEPTH, "credits granted after reset");
        end_test("credit_grant");

        repeat (RANDOM_LEN) random_cycle();
        end_test("random_rename");

        drain();
        drive_group(2, areg_t'(5), areg_t'(5), '0, '0, 0);
        saved_tag = m_tail - TAG_W'(1);
        drive_group(1, '0, '0, areg_t'(5), areg_t'(5), 0);
        check(int'(rename_out[0].src0.valid), 1, "same dest valid");
        check(int'(rename_out[0].src0.tag), int'(saved_tag), "same dest younger tag");
        end_test("same_dest");

        drain();
        drive_group(1, areg_t'(7), '0, '0, '0, 0);
        drive_group(1, areg_t'(7), '0, '0, '0, 0);
        saved_tag = m_tail - TAG_W'(1);
        drive_group(0, '0, '0, '0, '0, 1);
        drive_group(1, '0, '0, areg_t'(7), areg_t'(7), 0);
        check(int'(rename_out[0].src0.valid), 1, "newer mapping kept");
        check(int'(rename_out[0].src0.tag), int'(saved_tag), "newer mapping tag");
        drive_group(0, '0, '0, '0, '0, 1);
        drive_group(1, '0, '0, areg_t'(7), areg_t'(7), 0);
        check(int'(rename_out[0].src0.valid), 0, "released mapping");
        drain();
        end_test("conditional_release");

        repeat (RANDOM_LEN / 4) random_cycle();
        begin_cycle(1'b1);
        flush = 1'b1;
        apply_cycle('0, '0);
        model_clear();
        begin_cycle(1'b0);
        flush = 1'b0;
        check(int'(credit_return), 0, "credit during flush");
        apply_cycle('0, '0);
        for (int k = 0; k < GRANT_CYCLES; k++) begin
            begin_cycle(1'b0);
            check(int'(credit_return), GROUP_W, "grant after flush");
            apply_cycle('0, '0);
        end
        check(credits, ROB_DEPTH, "credits granted after flush");
        for (int k = 0; k < 4; k++) begin
            drive_group(1, '0, '0, areg_t'(2 * k), areg_t'(2 * k + 1), 0);
            check(int'(rename_out[0].src0.valid | rename_out[0].src1.valid), 0, "cleared table");
            check(int'(rename_out[0].dest_tag), k, "tag restart");
        end
        repeat (RANDOM_LEN) random_cycle();
        end_test("flush");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
